// ==== rtl/lsuTypesPkg.sv ====
// CPU-side width constant, access-size enum, request and response structs, byte swap function
package lsuTypesPkg;

  // Data and address width of the core side
  localparam int XLEN = 32;

  // Access size as carried by the memory-stage request
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } memSize_t;

  // Request from the memory stage
  // The wdata field holds the value in its low bits, not yet moved to a lane
  typedef struct packed {
    logic            write;
    memSize_t        size;
    logic            isUnsigned;
    logic            bigEndian;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } lsuReq_t;

  // Response to the pipeline, one per request and in request order
  // Stores and misaligned accesses return rdata of zero
  typedef struct packed {
    logic            write;
    logic            loadMisaligned;
    logic            storeMisaligned;
    logic [XLEN-1:0] rdata;
  } lsuRsp_t;

  // Reverses the byte order of a word
  // The hart works little-endian inside, so big-endian data is turned around at the edge
  function automatic logic [XLEN-1:0] swapBytes(input logic [XLEN-1:0] w);
    logic [XLEN-1:0] y;
    for (int i = 0; i < XLEN / 8; i++) begin
      y[8*i +: 8] = w[XLEN-8-8*i +: 8];
    end
    return y;
  endfunction

endpackage

// ==== rtl/busPkg.sv ====
// Data bus word constants and the bus request and response structs
package busPkg;

  // One bus beat carries one 32-bit word
  localparam int BUS_DATA_W     = 32;
  localparam int BYTES_PER_WORD = 4;

  // Low address bits that pick a byte inside the word
  localparam int BYTE_OFFSET_W  = $clog2(BYTES_PER_WORD);

  // The bus is addressed in words, so the byte offset bits are dropped
  localparam int BUS_ADDR_W     = 32 - BYTE_OFFSET_W;

  // Request beat toward the data memory
  // Loads carry a mask too, but the memory only looks at it for writes
  typedef struct packed {
    logic                      write;
    logic [BUS_ADDR_W-1:0]     wordAddr;
    logic [BYTES_PER_WORD-1:0] byteMask;
    logic [BUS_DATA_W-1:0]     wdata;
  } busReq_t;

  // Response beat from the data memory
  // Every request gets one, stores included, whose data is a don't-care
  typedef struct packed {
    logic [BUS_DATA_W-1:0] rdata;
  } busRsp_t;

endpackage

// ==== rtl/creditFifo.sv ====
// Credit-returning receive queue module with a type-parameterized payload
`timescale 1ns/1ns

module creditFifo #(
  parameter int  DEPTH     = 4,
  parameter type PAYLOAD_T = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     pushValid,
  input  PAYLOAD_T pushData,
  input  logic     pop,
  output logic     empty,
  output PAYLOAD_T headData,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Circular buffer with its read and write pointers and occupancy count
  PAYLOAD_T         mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  // The head is visible right after the edge that wrote it
  assign headData = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (pushValid) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // Pointers wrap by compare so any depth works
      if (pushValid) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({pushValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit goes back for every freed slot, one cycle after the pop
      credit <= pop;
    end
  end

  // The sender starts with DEPTH credits and spends one per push, so it
  // never overruns us, and the consumer only pops what it sees at the head
  pushPopLegal: assert property (@(posedge clk) disable iff (rst)
    !(pushValid && full) && !(pop && empty));

endmodule

// ==== rtl/storeFormat.sv ====
// Store formatter module with misalignment check, byte mask, lane replication and endian swap
`timescale 1ns/1ns

module storeFormat (
  input  lsuTypesPkg::lsuReq_t req,
  output busPkg::busReq_t      busReq,
  output logic                 misaligned
);

  import lsuTypesPkg::*;
  import busPkg::*;

  logic [BYTE_OFFSET_W-1:0]  offset;
  logic [BYTES_PER_WORD-1:0] mask;
  logic [BUS_DATA_W-1:0]     laneData;

  assign offset = req.addr[BYTE_OFFSET_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Subword write path
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req.size)
      MEM_BYTE: begin
        // A byte can sit anywhere in the word
        misaligned = 1'b0;
        mask       = BYTES_PER_WORD'(1) << offset;
        laneData   = {4{req.wdata[7:0]}};
      end
      MEM_HALF: begin
        // Halves live on even addresses only
        misaligned = offset[0];
        mask       = BYTES_PER_WORD'(2'b11) << {offset[1], 1'b0};
        laneData   = {2{req.wdata[15:0]}};
      end
      default: begin
        // Word access, and the unused size code is treated the same way
        misaligned = (offset != '0);
        mask       = '1;
        laneData   = req.wdata;
      end
    endcase
  end

  // The data is copied into every lane, so the mask alone decides which
  // bytes land in memory
  // Swapping the replicated word keeps the bytes of a half or word in
  // big-endian order while the mask still follows the byte address
  always_comb begin
    busReq.write    = req.write;
    busReq.wordAddr = req.addr[XLEN-1:BYTE_OFFSET_W];
    busReq.byteMask = mask;
    busReq.wdata    = req.bigEndian ? swapBytes(laneData) : laneData;
  end

endmodule

// ==== rtl/loadFormat.sv ====
// Load formatter module with endian swap, lane select and sign or zero extension
`timescale 1ns/1ns

module loadFormat (
  input  logic [lsuTypesPkg::XLEN-1:0] word,
  input  logic [1:0]                   offset,
  input  lsuTypesPkg::memSize_t        size,
  input  logic                         isUnsigned,
  input  logic                         bigEndian,
  output logic [lsuTypesPkg::XLEN-1:0] rdata
);

  import lsuTypesPkg::*;

  logic [XLEN-1:0] swapped;
  logic [1:0]      lane;
  logic [7:0]      byteSel;
  logic [15:0]     halfSel;
  logic            signBit;

  // Bring a big-endian word into little-endian order first
  assign swapped = bigEndian ? swapBytes(word) : word;

  // After the swap the addressed byte sits in the mirrored lane
  // Inverting the offset finds it for bytes, and bit 1 of the same value
  // picks the right half
  assign lane = bigEndian ? ~offset : offset;

  assign byteSel = swapped[8*lane +: 8];
  assign halfSel = lane[1] ? swapped[31:16] : swapped[15:0];

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (size)
      MEM_BYTE: begin
        signBit = byteSel[7] & ~isUnsigned;
        rdata   = {{24{signBit}}, byteSel};
      end
      MEM_HALF: begin
        signBit = halfSel[15] & ~isUnsigned;
        rdata   = {{16{signBit}}, halfSel};
      end
      default: begin
        // Whole words pass through, there is nothing to extend
        signBit = 1'b0;
        rdata   = swapped;
      end
    endcase
  end

endmodule

// ==== rtl/lsuCtrl.sv ====
// Load/store controller module with bus credit counter, pending-access queue and response register
`timescale 1ns/1ns

module lsuCtrl #(
  parameter int BUS_CREDITS = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         reqEmpty,
  input  lsuTypesPkg::lsuReq_t         req,
  input  logic                         misaligned,
  input  logic                         busReqCredit,
  input  logic                         rspEmpty,
  input  logic [lsuTypesPkg::XLEN-1:0] busWord,
  input  logic [lsuTypesPkg::XLEN-1:0] loadData,
  output logic                         reqPop,
  output logic                         busReqValid,
  output logic                         rspPop,
  output logic [1:0]                   pendOffset,
  output lsuTypesPkg::memSize_t        pendSize,
  output logic                         pendUnsigned,
  output logic                         pendBigEndian,
  output logic                         rspValid,
  output lsuTypesPkg::lsuRsp_t         rsp
);

  import lsuTypesPkg::*;

  localparam int CNT_W = $clog2(BUS_CREDITS + 1);
  localparam int PTR_W = (BUS_CREDITS > 1) ? $clog2(BUS_CREDITS) : 1;

  // What the retire side must remember about each popped request
  typedef struct packed {
    logic       write;
    memSize_t   size;
    logic       isUnsigned;
    logic       bigEndian;
    logic [1:0] offset;
    logic       loadMisaligned;
    logic       storeMisaligned;
  } pendEntry_t;

  pendEntry_t       pendMem [BUS_CREDITS];
  pendEntry_t       pendNew;
  pendEntry_t       pendHead;
  logic [PTR_W-1:0] pendWrPtr;
  logic [PTR_W-1:0] pendRdPtr;
  logic [CNT_W-1:0] pendCount;
  logic             pendEmpty;
  logic             pendFull;
  logic [CNT_W-1:0] creditCnt;
  logic [CNT_W-1:0] accessCnt;
  logic             headFault;
  logic             retire;

  ////////////////////////////////////////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////////////////////////////////////////

  assign pendEmpty = (pendCount == '0);
  assign pendFull  = (pendCount == CNT_W'(BUS_CREDITS));

  // A faulting request needs only a pending slot since it never goes out
  // An aligned one also needs a bus credit, and both go in the same cycle
  assign reqPop      = !reqEmpty && !pendFull && (misaligned || creditCnt != '0);
  assign busReqValid = reqPop && !misaligned;

  always_comb begin
    pendNew.write           = req.write;
    pendNew.size            = req.size;
    pendNew.isUnsigned      = req.isUnsigned;
    pendNew.bigEndian       = req.bigEndian;
    pendNew.offset          = req.addr[1:0];
    pendNew.loadMisaligned  = misaligned && !req.write;
    pendNew.storeMisaligned = misaligned && req.write;
  end

  // Memory grants BUS_CREDITS slots at reset and hands them back one by one
  always_ff @(posedge clk) begin
    if (rst) begin
      creditCnt <= CNT_W'(BUS_CREDITS);
      accessCnt <= '0;
    end else begin
      creditCnt <= creditCnt + CNT_W'(busReqCredit) - CNT_W'(busReqValid);
      // Accesses on the bus whose response has not been consumed yet
      accessCnt <= accessCnt + CNT_W'(busReqValid) - CNT_W'(rspPop);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending queue and in-order retire
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reqPop) begin
      pendMem[pendWrPtr] <= pendNew;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pendWrPtr <= '0;
      pendRdPtr <= '0;
      pendCount <= '0;
    end else begin
      if (reqPop) begin
        pendWrPtr <= (pendWrPtr == PTR_W'(BUS_CREDITS - 1)) ? '0 : pendWrPtr + 1'b1;
      end
      if (retire) begin
        pendRdPtr <= (pendRdPtr == PTR_W'(BUS_CREDITS - 1)) ? '0 : pendRdPtr + 1'b1;
      end
      pendCount <= pendCount + CNT_W'(reqPop) - CNT_W'(retire);
    end
  end

  assign pendHead  = pendMem[pendRdPtr];
  assign headFault = pendHead.loadMisaligned || pendHead.storeMisaligned;

  // Faults leave as soon as they reach the head, accesses wait for their beat
  assign retire = !pendEmpty && (headFault || !rspEmpty);
  assign rspPop = retire && !headFault;

  // The head entry steers the load formatter
  assign pendOffset    = pendHead.offset;
  assign pendSize      = pendHead.size;
  assign pendUnsigned  = pendHead.isUnsigned;
  assign pendBigEndian = pendHead.bigEndian;

  always_ff @(posedge clk) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= retire;
    end
  end

  // Stores and faults report zero data
  always_ff @(posedge clk) begin
    if (retire) begin
      rsp.write           <= pendHead.write;
      rsp.loadMisaligned  <= pendHead.loadMisaligned;
      rsp.storeMisaligned <= pendHead.storeMisaligned;
      rsp.rdata           <= (pendHead.write || headFault) ? '0 : loadData;
    end
  end

  // The memory must never return more credits than it was granted
  creditBound: assert property (@(posedge clk) disable iff (rst)
    creditCnt <= CNT_W'(BUS_CREDITS));

  // A beat in the response queue must belong to a request we issued
  rspOutstanding: assert property (@(posedge clk) disable iff (rst)
    !rspEmpty |-> accessCnt != '0);

  // Memory returns defined data for every load it answers
  loadWordKnown: assert property (@(posedge clk) disable iff (rst)
    (rspPop && !pendHead.write) |-> !$isunknown(busWord));

endmodule

// ==== rtl/lsuTop.sv ====
// Load/store unit top-level module with request and response queues, formatters and controller
`timescale 1ns/1ns

module lsuTop #(
  parameter int REQ_DEPTH   = 4,
  parameter int RSP_DEPTH   = 4,
  parameter int BUS_CREDITS = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  // Memory-stage request side
  input  logic                 reqValid,
  input  lsuTypesPkg::lsuReq_t req,
  output logic                 reqCredit,
  // Pipeline response side, no back-pressure
  output logic                 rspValid,
  output lsuTypesPkg::lsuRsp_t rsp,
  // Data bus request side
  output logic                 busReqValid,
  output busPkg::busReq_t      busReq,
  input  logic                 busReqCredit,
  // Data bus response side
  input  logic                 busRspValid,
  input  busPkg::busRsp_t      busRsp,
  output logic                 busRspCredit
);

  import lsuTypesPkg::*;
  import busPkg::*;

  lsuReq_t         reqHead;
  logic            reqEmpty;
  logic            reqPop;
  logic            misaligned;
  busRsp_t         rspHead;
  logic            rspEmpty;
  logic            rspPop;
  logic [1:0]      pendOffset;
  memSize_t        pendSize;
  logic            pendUnsigned;
  logic            pendBigEndian;
  logic [XLEN-1:0] loadData;

  ////////////////////////////////////////////////////////////////////////////
  // Queues
  ////////////////////////////////////////////////////////////////////////////

  // Requests from the pipeline wait here until a slot and a credit are free
  creditFifo #(.DEPTH(REQ_DEPTH), .PAYLOAD_T(lsuReq_t)) i_reqFifo (
    .clk, .rst,
    .pushValid(reqValid), .pushData(req), .pop(reqPop),
    .empty(reqEmpty), .headData(reqHead), .credit(reqCredit));

  // Bus beats come back in order and are drained one per retired access
  creditFifo #(.DEPTH(RSP_DEPTH), .PAYLOAD_T(busRsp_t)) i_rspFifo (
    .clk, .rst,
    .pushValid(busRspValid), .pushData(busRsp), .pop(rspPop),
    .empty(rspEmpty), .headData(rspHead), .credit(busRspCredit));

  ////////////////////////////////////////////////////////////////////////////
  // Datapath and control
  ////////////////////////////////////////////////////////////////////////////

  storeFormat i_storeFormat (.req(reqHead), .busReq, .misaligned);

  loadFormat i_loadFormat (
    .word(rspHead.rdata), .offset(pendOffset), .size(pendSize),
    .isUnsigned(pendUnsigned), .bigEndian(pendBigEndian), .rdata(loadData));

  lsuCtrl #(.BUS_CREDITS(BUS_CREDITS)) i_lsuCtrl (
    .clk, .rst,
    .reqEmpty, .req(reqHead), .misaligned, .busReqCredit,
    .rspEmpty, .busWord(rspHead.rdata), .loadData,
    .reqPop, .busReqValid, .rspPop,
    .pendOffset, .pendSize, .pendUnsigned, .pendBigEndian,
    .rspValid, .rsp);

endmodule

// ==== testbench/lsuTb.sv ====
// Load/store unit testbench with clock, credit-based memory model, reference model, LFSR and tests
`timescale 1ns/1ns

module lsuTb;

  import lsuTypesPkg::*;
  import busPkg::*;

  // These match the DUT defaults, which stay untouched
  localparam int          REQ_DEPTH   = 4;
  localparam int          RSP_DEPTH   = 4;
  localparam int          BUS_CREDITS = 4;
  localparam int          TIMEOUT     = 200;
  localparam logic [31:0] LFSR_TAPS   = 32'hA300_0000;

  logic    clk;
  logic    rst;
  logic    reqValid;
  lsuReq_t req;
  logic    reqCredit;
  logic    rspValid;
  lsuRsp_t rsp;
  logic    busReqValid;
  busReq_t busReq;
  logic    busReqCredit = 1'b0;
  logic    busRspValid  = 1'b0;
  busRsp_t busRsp       = '0;
  logic    busRspCredit;

  // The stall and the credit hold draw bits on rising edges and the stimulus on falling edges
  logic [31:0] lfsrState  = 32'h3414;
  logic        stallOn    = 1'b0;
  logic        stall      = 1'b0;
  logic        creditHold = 1'b0;

  logic [31:0] memWords [256];
  logic [7:0]  refBytes [1024];
  busReq_t     memQ [$];
  busReq_t     expBus [$];
  lsuRsp_t     expRsp [$];
  int          memRspCredits   = RSP_DEPTH;
  int          creditsOwed     = 0;
  int          busIssued       = 0;
  int          busCredited     = 0;
  int          creditsReturned = 0;
  int          reqsSent        = 0;
  int          rspCount        = 0;
  int          valueErrors     = 0;
  int          otherErrors     = 0;

  lsuTop i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helper functions
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit with the bits gathered oldest first
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LFSR_TAPS) : (lfsrState >> 1);
    end
    return v;
  endfunction

  // Every bit of the word index shapes the fill word
  function automatic logic [31:0] fillWord(input int i);
    logic [7:0] b;
    b = 8'(i);
    return {b ^ 8'h5A, ~b, b + 8'h3C, {b[3:0], b[7:4]}};
  endfunction

  function automatic int sizeBytes(input memSize_t s);
    return (s == MEM_BYTE) ? 1 : (s == MEM_HALF) ? 2 : 4;
  endfunction

  function automatic lsuReq_t mkReq(input logic write, input memSize_t size, input logic uns,
                                    input logic be, input logic [31:0] addr,
                                    input logic [31:0] wdata);
    lsuReq_t r;
    r.write      = write;
    r.size       = size;
    r.isUnsigned = uns;
    r.bigEndian  = be;
    r.addr       = addr;
    r.wdata      = wdata;
    return r;
  endfunction

  // Lanes repeat the value every n bytes and big-endian mirrors the whole word
  function automatic busReq_t expectBus(input lsuReq_t r);
    busReq_t b;
    int      n;
    int      off;
    int      src;
    n          = sizeBytes(r.size);
    off        = int'(r.addr[1:0]);
    b.write    = r.write;
    b.wordAddr = r.addr[31:2];
    for (int j = 0; j < 4; j++) begin
      src               = r.bigEndian ? (3 - j) % n : j % n;
      b.wdata[8*j +: 8] = r.wdata[8*src +: 8];
      b.byteMask[j]     = (j >= off) && (j < off + n);
    end
    return b;
  endfunction

  function automatic lsuReq_t randomReq();
    lsuReq_t    r;
    logic [1:0] sz;
    r.write      = 1'(takeBits(1));
    sz           = 2'(takeBits(2));
    r.size       = (sz == 2'b11) ? MEM_WORD : memSize_t'(sz);
    r.isUnsigned = 1'(takeBits(1));
    r.bigEndian  = 1'(takeBits(1));
    // A small window so that loads often hit earlier stores
    r.addr       = 32'h200 + takeBits(6);
    // Three in four get their low bits cleared and the rest may fault
    if (takeBits(2) != 32'd3) begin
      r.addr[1:0] = (r.size == MEM_WORD) ? 2'b00 :
                    (r.size == MEM_HALF) ? {r.addr[1], 1'b0} : r.addr[1:0];
    end
    r.wdata = takeBits(32);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkRsp(input lsuRsp_t got, input lsuRsp_t exp);
    if (got !== exp) begin
      valueErrors++;
      $display("error: rsp is %h, expected %h", got, exp);
    end
  endtask

  task automatic checkBusReq(input busReq_t got, input busReq_t exp);
    if (got !== exp) begin
      valueErrors++;
      $display("error: busReq is %h, expected %h", got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got !== exp) begin
      valueErrors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and monitors
  ////////////////////////////////////////////////////////////////////////////

  // Serves before it queues, so the earliest response comes a cycle after the request
  // Each served request owes one credit, and the hold bit can delay its return
  always @(negedge clk) begin : memoryModel
    busReq_t    head;
    logic [7:0] idx;
    busReqCredit = 1'b0;
    busRspValid  = 1'b0;
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        memWords[i] = fillWord(i);
      end
    end else begin
      if (busRspCredit) begin
        memRspCredits++;
      end
      if (memQ.size() > 0 && memRspCredits > 0 && !stall) begin
        head = memQ.pop_front();
        idx  = head.wordAddr[7:0];
        for (int k = 0; k < 4; k++) begin
          if (head.write && head.byteMask[k]) begin
            memWords[idx][8*k +: 8] = head.wdata[8*k +: 8];
          end
        end
        // Stores get the word back too, and the DUT drops it
        busRsp.rdata = memWords[idx];
        busRspValid  = 1'b1;
        memRspCredits--;
        creditsOwed++;
      end
      if (creditsOwed > 0 && !creditHold) begin
        busReqCredit = 1'b1;
        creditsOwed--;
        busCredited++;
      end
      if (busReqValid) begin
        if (expBus.size() == 0) begin
          otherErrors++;
          $display("A bus request appeared that no access should have made");
        end else begin
          checkBusReq(busReq, expBus.pop_front());
        end
        memQ.push_back(busReq);
        busIssued++;
      end
      if (busIssued - busCredited > BUS_CREDITS) begin
        otherErrors++;
        $display("More bus requests are outstanding than the memory granted");
      end
    end
  end

  always @(negedge clk) begin : rspMonitor
    if (!rst && rspValid) begin
      rspCount++;
      if (expRsp.size() == 0) begin
        otherErrors++;
        $display("A response arrived with no request outstanding");
      end else begin
        checkRsp(rsp, expRsp.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && reqCredit) begin
      creditsReturned <= creditsReturned + 1;
    end
    stall      <= stallOn ? 1'(takeBits(1)) : 1'b0;
    creditHold <= stallOn ? 1'(takeBits(1)) : 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////////////////////

  // Drives one request and records what the DUT must do with it
  task automatic send(input lsuReq_t r);
    lsuRsp_t     exp;
    logic [31:0] value;
    logic        bad;
    int          n;
    int          pos;
    int          waited;
    n      = sizeBytes(r.size);
    bad    = (n == 2 && r.addr[0]) || (n == 4 && r.addr[1:0] != 2'b00);
    value  = '0;
    waited = 0;
    @(negedge clk);
    while (REQ_DEPTH + creditsReturned - reqsSent <= 0 && waited < TIMEOUT) begin
      reqValid = 1'b0;
      @(negedge clk);
      waited++;
    end
    if (REQ_DEPTH + creditsReturned - reqsSent <= 0) begin
      otherErrors++;
      $display("Timed out waiting for a request credit");
      return;
    end
    reqValid = 1'b1;
    req      = r;
    reqsSent++;
    if (!bad) begin
      expBus.push_back(expectBus(r));
      // Byte i sits at addr + i, counted from the top in big-endian order
      for (int i = 0; i < n; i++) begin
        pos = r.bigEndian ? n - 1 - i : i;
        if (r.write) begin
          refBytes[int'(r.addr[9:0]) + i] = r.wdata[8*pos +: 8];
        end else begin
          value[8*pos +: 8] = refBytes[int'(r.addr[9:0]) + i];
        end
      end
      if (n < 4 && !r.isUnsigned && value[8*n-1]) begin
        value = value | (32'hFFFF_FFFF << (8 * n));
      end
    end
    exp.write           = r.write;
    exp.loadMisaligned  = bad && !r.write;
    exp.storeMisaligned = bad && r.write;
    exp.rdata           = r.write ? '0 : value;
    expRsp.push_back(exp);
  endtask

  // Drains every expected response, then checks the running totals
  task automatic waitIdle();
    int waited;
    waited = 0;
    @(negedge clk);
    reqValid = 1'b0;
    while (expRsp.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (expRsp.size() != 0) begin
      otherErrors++;
      $display("Timed out with %0d responses still missing", expRsp.size());
      expRsp.delete();
    end
    repeat (4) @(negedge clk);
    checkCount("reqCredit pulses", creditsReturned, reqsSent);
    checkCount("responses", rspCount, reqsSent);
    checkCount("unissued bus requests", expBus.size(), 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idleAfterReset();
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      checkCount("rspValid", int'(rspValid), 0);
      checkCount("busReqValid", int'(busReqValid), 0);
      checkCount("reqCredit", int'(reqCredit), 0);
      checkCount("busRspCredit", int'(busRspCredit), 0);
    end
  endtask

  task automatic roundTripWord();
    send(mkReq(1'b1, MEM_WORD, 1'b0, 1'b0, 32'h40, 32'h1234_5678));
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b0, 32'h40, 32'h0));
    waitIdle();
  endtask

  // Values straddle the sign bit so both extensions show
  task automatic subwordAccess();
    for (int o = 0; o < 4; o++) begin
      send(mkReq(1'b1, MEM_BYTE, 1'b0, 1'b0, 32'h60 + 32'(o), 32'hABCD_EF7E + 32'(o)));
    end
    for (int o = 0; o < 4; o++) begin
      send(mkReq(1'b0, MEM_BYTE, 1'b0, 1'b0, 32'h60 + 32'(o), 32'h0));
      send(mkReq(1'b0, MEM_BYTE, 1'b1, 1'b0, 32'h60 + 32'(o), 32'h0));
    end
    for (int o = 0; o < 4; o += 2) begin
      send(mkReq(1'b1, MEM_HALF, 1'b0, 1'b0, 32'h68 + 32'(o), 32'h5555_7FFE + 32'(o)));
      send(mkReq(1'b0, MEM_HALF, 1'b0, 1'b0, 32'h68 + 32'(o), 32'h0));
      send(mkReq(1'b0, MEM_HALF, 1'b1, 1'b0, 32'h68 + 32'(o), 32'h0));
    end
    waitIdle();
  endtask

  task automatic bigEndianAccess();
    send(mkReq(1'b1, MEM_WORD, 1'b0, 1'b1, 32'h80, 32'hA1B2_C3D4));
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b1, 32'h80, 32'h0));
    // Little-endian view of the same word shows the bytes turned around
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b0, 32'h80, 32'h0));
    send(mkReq(1'b0, MEM_HALF, 1'b0, 1'b1, 32'h80, 32'h0));
    send(mkReq(1'b0, MEM_HALF, 1'b1, 1'b1, 32'h82, 32'h0));
    for (int o = 0; o < 4; o++) begin
      send(mkReq(1'b0, MEM_BYTE, o[0], 1'b1, 32'h80 + 32'(o), 32'h0));
    end
    send(mkReq(1'b1, MEM_HALF, 1'b0, 1'b1, 32'h84, 32'h0000_8A5C));
    send(mkReq(1'b1, MEM_HALF, 1'b0, 1'b1, 32'h86, 32'h0000_3CF1));
    send(mkReq(1'b1, MEM_BYTE, 1'b0, 1'b1, 32'h87, 32'h0000_00E9));
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b0, 32'h84, 32'h0));
    send(mkReq(1'b0, MEM_HALF, 1'b0, 1'b1, 32'h84, 32'h0));
    send(mkReq(1'b0, MEM_HALF, 1'b1, 1'b1, 32'h86, 32'h0));
    waitIdle();
  endtask

  // Faults sit between aligned accesses so their order is visible
  task automatic misalignedFaults();
    send(mkReq(1'b1, MEM_WORD, 1'b0, 1'b0, 32'h100, 32'hCAFE_F00D));
    send(mkReq(1'b0, MEM_HALF, 1'b0, 1'b0, 32'h101, 32'h0));
    send(mkReq(1'b1, MEM_WORD, 1'b0, 1'b0, 32'h102, 32'h1111_2222));
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b0, 32'h100, 32'h0));
    send(mkReq(1'b0, MEM_WORD, 1'b0, 1'b1, 32'h103, 32'h0));
    send(mkReq(1'b1, MEM_HALF, 1'b0, 1'b1, 32'h105, 32'h0000_7777));
    send(mkReq(1'b0, MEM_BYTE, 1'b0, 1'b0, 32'h105, 32'h0));
    waitIdle();
  endtask

  task automatic randomBurst();
    stallOn = 1'b1;
    for (int i = 0; i < 40; i++) begin
      send(randomReq());
    end
    waitIdle();
    stallOn = 1'b0;
  endtask

  initial begin : main
    logic [31:0] w;
    rst      = 1'b1;
    reqValid = 1'b0;
    req      = '0;
    for (int i = 0; i < 256; i++) begin
      w = fillWord(i);
      for (int k = 0; k < 4; k++) begin
        refBytes[4*i + k] = w[8*k +: 8];
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idleAfterReset();
    roundTripWord();
    subwordAccess();
    bigEndianAccess();
    misalignedFaults();
    randomBurst();
    $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/lsuTypesPkg.sv
rtl/busPkg.sv
rtl/creditFifo.sv
rtl/storeFormat.sv
rtl/loadFormat.sv
rtl/lsuCtrl.sv
rtl/lsuTop.sv
testbench/lsuTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the load/store unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsuTb -f files.f -o simLsu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simLsu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
